//--- build.f
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/pipe_reg_stage.sv
hw/way_store.sv
hw/miss_controller.sv
hw/dcache_top.sv
testbench/dcache_assertions.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv

//--- hw/cache_bus_pkg.sv
package cache_bus_pkg;

    // core side
    typedef struct packed {
        logic [cache_cfg_pkg::ADDR_W-1:0] addr;
        logic                             we;
        logic [cache_cfg_pkg::DATA_W-1:0] wdata;
        logic [cache_cfg_pkg::MASK_W-1:0] mask;
    } cpu_req_t;

    // rdata is zero for stores
    typedef struct packed {
        logic [cache_cfg_pkg::DATA_W-1:0] rdata;
        logic                             we;
    } cpu_rsp_t;

    // memory side
    typedef struct packed {
        logic [cache_cfg_pkg::ADDR_W-1:0] addr;
        logic                             we;
        logic [cache_cfg_pkg::DATA_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic [cache_cfg_pkg::DATA_W-1:0] data;
    } mem_rsp_t;

    // store merge into a hit way
    typedef struct packed {
        logic                             we;
        logic                             way;
        logic [cache_cfg_pkg::DATA_W-1:0] wdata;
        logic [cache_cfg_pkg::MASK_W-1:0] mask;
    } way_upd_t;

endpackage

//--- hw/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // address split: tag | index | byte offset
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int MASK_W   = DATA_W / 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int SETS     = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // replacement age counters
    localparam int AGE_W    = 3;
    localparam int AGE_MAX  = (1 << AGE_W) - 1;

    localparam int WAYS     = 2;

endpackage

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  cache_bus_pkg::cpu_req_t req_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output cache_bus_pkg::cpu_rsp_t rsp_o,
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output cache_bus_pkg::mem_req_t mem_req_o,
    input  logic                    mem_rsp_valid_i,
    input  cache_bus_pkg::mem_rsp_t mem_rsp_i
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    logic              ctrl_req_valid;
    logic              ctrl_req_ready;
    cpu_req_t          ctrl_req;
    logic              ctrl_rsp_valid;
    logic              ctrl_rsp_ready;
    cpu_rsp_t          ctrl_rsp;

    // controller to way arrays
    logic [ADDR_W-1:0] lookup_addr;
    way_upd_t          hit_update;
    logic              touch;
    logic              fill;
    logic              fill_way;
    logic [DATA_W-1:0] fill_data;
    logic              hit;
    logic              hit_way;
    logic [DATA_W-1:0] rdata;
    logic              victim_way;
    logic              victim_dirty;
    logic [TAG_W-1:0]  victim_tag;
    logic [DATA_W-1:0] victim_data;

    pipe_reg_stage #(.payload_t(cpu_req_t)) u_req_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .in_data_i   (req_i),
        .out_valid_o (ctrl_req_valid),
        .out_ready_i (ctrl_req_ready),
        .out_data_o  (ctrl_req)
    );

    miss_controller u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (ctrl_req_valid),
        .req_ready_o     (ctrl_req_ready),
        .req_i           (ctrl_req),
        .rsp_valid_o     (ctrl_rsp_valid),
        .rsp_ready_i     (ctrl_rsp_ready),
        .rsp_o           (ctrl_rsp),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .lookup_addr_o   (lookup_addr),
        .hit_update_o    (hit_update),
        .touch_o         (touch),
        .fill_o          (fill),
        .fill_way_o      (fill_way),
        .fill_data_o     (fill_data),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .rdata_i         (rdata),
        .victim_way_i    (victim_way),
        .victim_dirty_i  (victim_dirty),
        .victim_tag_i    (victim_tag),
        .victim_data_i   (victim_data)
    );

    way_store u_ways (
        .clk            (clk),
        .rst            (rst),
        .lookup_addr_i  (lookup_addr),
        .hit_update_i   (hit_update),
        .touch_i        (touch),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .fill_data_i    (fill_data),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .rdata_o        (rdata),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_data_o  (victim_data)
    );

    pipe_reg_stage #(.payload_t(cpu_rsp_t)) u_rsp_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (ctrl_rsp_valid),
        .in_ready_o  (ctrl_rsp_ready),
        .in_data_i   (ctrl_rsp),
        .out_valid_o (rsp_valid_o),
        .out_ready_i (rsp_ready_i),
        .out_data_o  (rsp_o)
    );

endmodule

//--- hw/miss_controller.sv
`timescale 1ns/1ps

module miss_controller (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_valid_i,
    output logic                             req_ready_o,
    input  cache_bus_pkg::cpu_req_t          req_i,
    output logic                             rsp_valid_o,
    input  logic                             rsp_ready_i,
    output cache_bus_pkg::cpu_rsp_t          rsp_o,
    output logic                             mem_req_valid_o,
    input  logic                             mem_req_ready_i,
    output cache_bus_pkg::mem_req_t          mem_req_o,
    input  logic                             mem_rsp_valid_i,
    input  cache_bus_pkg::mem_rsp_t          mem_rsp_i,
    output logic [cache_cfg_pkg::ADDR_W-1:0] lookup_addr_o,
    output cache_bus_pkg::way_upd_t          hit_update_o,
    output logic                             touch_o,
    output logic                             fill_o,
    output logic                             fill_way_o,
    output logic [cache_cfg_pkg::DATA_W-1:0] fill_data_o,
    input  logic                             hit_i,
    input  logic                             hit_way_i,
    input  logic [cache_cfg_pkg::DATA_W-1:0] rdata_i,
    input  logic                             victim_way_i,
    input  logic                             victim_dirty_i,
    input  logic [cache_cfg_pkg::TAG_W-1:0]  victim_tag_i,
    input  logic [cache_cfg_pkg::DATA_W-1:0] victim_data_i
);
    import cache_cfg_pkg::*;

    typedef enum logic [2:0] {
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        REPLAY
    } state_t;

    state_t             state_q;
    state_t             state_d;
    logic               serving;
    logic               done;
    logic [INDEX_W-1:0] index;

    // request stage holds the request until done, so no local copy
    assign index         = req_i.addr[OFFSET_W +: INDEX_W];
    assign lookup_addr_o = req_i.addr;

    assign serving     = (state_q == LOOKUP) || (state_q == REPLAY);
    assign rsp_valid_o = serving && req_valid_i && hit_i;
    assign done        = rsp_valid_o && rsp_ready_i;
    assign req_ready_o = done;

    assign rsp_o.rdata = req_i.we ? '0 : rdata_i;
    assign rsp_o.we    = req_i.we;

    // array updates only on completion
    assign touch_o            = done;
    assign hit_update_o.we    = done && req_i.we;
    assign hit_update_o.way   = hit_way_i;
    assign hit_update_o.wdata = req_i.wdata;
    assign hit_update_o.mask  = req_i.mask;

    assign fill_o      = (state_q == REFILL_WAIT) && mem_rsp_valid_i;
    assign fill_way_o  = victim_way_i;
    assign fill_data_o = mem_rsp_i.data;

    always_comb begin
        mem_req_valid_o = 1'b0;
        mem_req_o       = '0;
        case (state_q)
            WRITEBACK: begin
                // victim address rebuilt from its tag and this index
                mem_req_valid_o = 1'b1;
                mem_req_o.addr  = {victim_tag_i, index, {OFFSET_W{1'b0}}};
                mem_req_o.we    = 1'b1;
                mem_req_o.data  = victim_data_i;
            end
            REFILL_REQ: begin
                mem_req_valid_o = 1'b1;
                mem_req_o.addr  = {req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (req_valid_i && !hit_i) begin
                    state_d = victim_dirty_i ? WRITEBACK : REFILL_REQ;
                end
            end
            WRITEBACK: begin
                if (mem_req_ready_i) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = REPLAY;
                end
            end
            // line is present now, finish through the hit path
            REPLAY: begin
                if (done) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- hw/pipe_reg_stage.sv
`timescale 1ns/1ps

module pipe_reg_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // refill while the held item drains
    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

endmodule

//--- hw/way_store.sv
`timescale 1ns/1ps

module way_store (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cache_cfg_pkg::ADDR_W-1:0] lookup_addr_i,
    input  cache_bus_pkg::way_upd_t          hit_update_i,
    input  logic                             touch_i,
    input  logic                             fill_i,
    input  logic                             fill_way_i,
    input  logic [cache_cfg_pkg::DATA_W-1:0] fill_data_i,
    output logic                             hit_o,
    output logic                             hit_way_o,
    output logic [cache_cfg_pkg::DATA_W-1:0] rdata_o,
    output logic                             victim_way_o,
    output logic                             victim_dirty_o,
    output logic [cache_cfg_pkg::TAG_W-1:0]  victim_tag_o,
    output logic [cache_cfg_pkg::DATA_W-1:0] victim_data_o
);
    import cache_cfg_pkg::*;

    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic [WAYS-1:0]    way_hit;

    logic [SETS-1:0]    valid_q [WAYS];
    logic [SETS-1:0]    dirty_q [WAYS];
    logic [AGE_W-1:0]   age_q   [WAYS][SETS];
    logic [TAG_W-1:0]   tag_q   [WAYS][SETS];
    logic [DATA_W-1:0]  data_q  [WAYS][SETS];

    assign idx = lookup_addr_i[OFFSET_W +: INDEX_W];
    assign tag = lookup_addr_i[ADDR_W-1 -: TAG_W];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
        end
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];
    assign rdata_o   = data_q[hit_way_o][idx];

    // empty way first, then the older one, way 0 on a tie
    always_comb begin
        if (!valid_q[0][idx]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = age_q[1][idx] > age_q[0][idx];
        end
    end

    assign victim_dirty_o = valid_q[victim_way_o][idx] && dirty_q[victim_way_o][idx];
    assign victim_tag_o   = tag_q[victim_way_o][idx];
    assign victim_data_o  = data_q[victim_way_o][idx];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
                for (int s = 0; s < SETS; s++) begin
                    age_q[w][s] <= '0;
                end
            end
        end else begin
            // fill lands clean, a replayed store dirties it later
            if (fill_i) begin
                valid_q[fill_way_i][idx] <= 1'b1;
                dirty_q[fill_way_i][idx] <= 1'b0;
            end
            if (hit_update_i.we) begin
                dirty_q[hit_update_i.way][idx] <= 1'b1;
            end
            if (touch_i) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (w == int'(hit_way_o)) begin
                        age_q[w][idx] <= '0;
                    end else if (age_q[w][idx] != AGE_W'(AGE_MAX)) begin
                        age_q[w][idx] <= age_q[w][idx] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_way_i][idx]  <= tag;
            data_q[fill_way_i][idx] <= fill_data_i;
        end
        if (hit_update_i.we) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (hit_update_i.mask[b]) begin
                    data_q[hit_update_i.way][idx][8*b +: 8] <= hit_update_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module dcache_tb -o dcache_sim

output="$(./obj_dir/dcache_sim 2>&1)" || true
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1

//--- testbench/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    req_valid_i,
    input logic                    req_ready_i,
    input cache_bus_pkg::cpu_req_t req_i,
    input logic                    rsp_valid_i,
    input logic                    rsp_ready_i,
    input cache_bus_pkg::cpu_rsp_t rsp_i,
    input logic                    mem_req_valid_i,
    input logic                    mem_req_ready_i,
    input cache_bus_pkg::mem_req_t mem_req_i
);

    int fail_count = 0;

    // a stalled channel keeps valid high and its payload stable
    assert property (@(posedge clk) disable iff (!rst)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else begin
        $error("request channel dropped valid or changed payload while stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
        $error("response channel dropped valid or changed payload while stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
    else begin
        $error("memory request dropped valid or changed payload while stalled");
        fail_count++;
    end

    assert property (@(posedge clk) !rst |-> !rsp_valid_i && !mem_req_valid_i)
    else begin
        $error("valid output high during reset");
        fail_count++;
    end

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_ready_i     (req_ready_o),
    .req_i           (req_i),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_i           (rsp_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_i       (mem_req_o)
);

//--- testbench/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_valid_i,
    input  logic                             req_ready_i,
    input  cache_bus_pkg::cpu_req_t          req_i,
    input  logic [63:0]                      row_name_i,
    input  logic                             row_fixed_i,
    input  logic [cache_cfg_pkg::DATA_W-1:0] row_exp_i,
    input  logic                             rsp_valid_i,
    input  logic                             rsp_ready_i,
    input  cache_bus_pkg::cpu_rsp_t          rsp_i,
    input  logic                             mem_req_valid_i,
    input  logic                             mem_req_ready_i,
    input  cache_bus_pkg::mem_req_t          mem_req_i,
    output int                               error_count_o,
    output int                               rsp_count_o
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    typedef struct packed {
        logic [63:0]       name;
        logic              we;
        logic [DATA_W-1:0] value;
        logic              fixed;
        logic [DATA_W-1:0] fixed_value;
    } pending_t;

    logic [DATA_W-1:0] shadow [logic [ADDR_W-OFFSET_W-1:0]];
    logic              dirty_words [logic [ADDR_W-OFFSET_W-1:0]];
    pending_t          pending_q [$];
    pending_t          entry;
    int                error_count = 0;
    int                rsp_count = 0;

    assign error_count_o = error_count;
    assign rsp_count_o   = rsp_count;

    function automatic logic [DATA_W-1:0] shadow_read(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        if (shadow.exists(addr[ADDR_W-1:OFFSET_W])) begin
            return shadow[addr[ADDR_W-1:OFFSET_W]];
        end
        return {base, base};
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [MASK_W-1:0] mask);
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return word;
    endfunction

    task automatic check_value(input logic [63:0] name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            // responses first as they belong to older requests
            if (rsp_valid_i && rsp_ready_i) begin
                rsp_count++;
                if (pending_q.size() == 0) begin
                    $display("response arrived with no request outstanding");
                    error_count++;
                end else begin
                    entry = pending_q.pop_front();
                    check_value(entry.name, entry.value, rsp_i.rdata);
                    if (entry.fixed) begin
                        check_value(entry.name, entry.fixed_value, rsp_i.rdata);
                    end
                    if (rsp_i.we !== entry.we) begin
                        $display("response kind for %s does not match its request", entry.name);
                        error_count++;
                    end
                end
            end
            if (req_valid_i && req_ready_i) begin
                entry.name        = row_name_i;
                entry.we          = req_i.we;
                entry.fixed       = row_fixed_i;
                entry.fixed_value = row_exp_i;
                if (req_i.we) begin
                    shadow[req_i.addr[ADDR_W-1:OFFSET_W]] =
                        merge_bytes(shadow_read(req_i.addr), req_i.wdata, req_i.mask);
                    dirty_words[req_i.addr[ADDR_W-1:OFFSET_W]] = 1'b1;
                    entry.value = '0;
                end else begin
                    entry.value = shadow_read(req_i.addr);
                end
                pending_q.push_back(entry);
            end
            // write-back only for a stored line, carrying the latest stored data
            if (mem_req_valid_i && mem_req_ready_i && mem_req_i.we) begin
                check_value("wrback  ", shadow_read(mem_req_i.addr), mem_req_i.data);
                if (!dirty_words.exists(mem_req_i.addr[ADDR_W-1:OFFSET_W])) begin
                    $display("memory write at %h for a line that holds no new store",
                             mem_req_i.addr);
                    error_count++;
                end else begin
                    dirty_words.delete(mem_req_i.addr[ADDR_W-1:OFFSET_W]);
                end
            end
        end
    end

endmodule

//--- testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam int ROWS         = 14;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT      = ROWS * 64 + RESET_CYCLES;

    typedef struct packed {
        logic [63:0]       name;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [MASK_W-1:0] mask;
        logic              fixed;
        logic [DATA_W-1:0] exp_data;
    } row_t;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    cpu_req_t          req;
    logic              rsp_valid;
    logic              rsp_ready;
    cpu_rsp_t          rsp;
    logic              mem_req_valid;
    logic              mem_req_ready;
    mem_req_t          mem_req;
    logic              mem_rsp_valid;
    mem_rsp_t          mem_rsp;

    logic [63:0]       row_name;
    logic              row_fixed;
    logic [DATA_W-1:0] row_exp;
    int                check_errors;
    int                rsp_count;
    int                cycle_count;
    int                count_errors;
    logic [2:0]        rd_wait;
    logic [15:0]       lfsr_q = 16'd77;
    logic [DATA_W-1:0] mem [logic [ADDR_W-OFFSET_W-1:0]];
    row_t              rows [ROWS];

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit taken
    function automatic logic [3:0] rand_bits(input int count);
        logic [3:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[2:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    // untouched memory holds its own word address in both halves
    function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        if (mem.exists(addr[ADDR_W-1:OFFSET_W])) begin
            return mem[addr[ADDR_W-1:OFFSET_W]];
        end
        return {base, base};
    endfunction

    always #2 clk = ~clk;

    dcache_top u_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .req_i           (req),
        .rsp_valid_o     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .rsp_o           (rsp),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_o       (mem_req),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_i       (mem_rsp)
    );

    dcache_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_ready_i     (req_ready),
        .req_i           (req),
        .row_name_i      (row_name),
        .row_fixed_i     (row_fixed),
        .row_exp_i       (row_exp),
        .rsp_valid_i     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .rsp_i           (rsp),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_i       (mem_req),
        .error_count_o   (check_errors),
        .rsp_count_o     (rsp_count)
    );

    // memory model and random stalls, all draws in one fixed order
    always @(posedge clk) begin
        if (!rst) begin
            rsp_ready     <= 1'b0;
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            rd_wait       <= '0;
        end else begin
            rsp_ready     <= rand_bits(2) != 4'd0;
            mem_req_ready <= rand_bits(1) == 4'd1;
            mem_rsp_valid <= 1'b0;
            if (rd_wait != 3'd0) begin
                rd_wait <= rd_wait - 3'd1;
                if (rd_wait == 3'd1) begin
                    mem_rsp_valid <= 1'b1;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.we) begin
                    mem[mem_req.addr[ADDR_W-1:OFFSET_W]] = mem_req.data;
                end else begin
                    rd_wait      <= 3'd1 + 3'(rand_bits(2));
                    mem_rsp.data <= mem_read(mem_req.addr);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: only %0d of %0d responses after %0d cycles",
                     rsp_count, ROWS, TIMEOUT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        // A, B and C share set 8 with different tags
        rows[0]  = '{"cold_ld ", 1'b0, 32'h0000_0100, 64'h0, 8'h00, 1'b1,
                     64'h0000_0100_0000_0100};
        rows[1]  = '{"st_a_lo ", 1'b1, 32'h0000_1040, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F,
                     1'b0, 64'h0};
        rows[2]  = '{"ld_a_mrg", 1'b0, 32'h0000_1040, 64'h0, 8'h00, 1'b1,
                     64'h0000_1040_CCCC_DDDD};
        rows[3]  = '{"ld_b_new", 1'b0, 32'h0000_2040, 64'h0, 8'h00, 1'b1,
                     64'h0000_2040_0000_2040};
        rows[4]  = '{"ld_c_evA", 1'b0, 32'h0000_3040, 64'h0, 8'h00, 1'b1,
                     64'h0000_3040_0000_3040};
        rows[5]  = '{"ld_a_wb ", 1'b0, 32'h0000_1040, 64'h0, 8'h00, 1'b1,
                     64'h0000_1040_CCCC_DDDD};
        rows[6]  = '{"st_a_hi ", 1'b1, 32'h0000_1040, 64'h1122_3344_5566_7788, 8'hF0,
                     1'b0, 64'h0};
        rows[7]  = '{"ld_cold2", 1'b0, 32'h0000_0100, 64'h0, 8'h00, 1'b1,
                     64'h0000_0100_0000_0100};
        rows[8]  = '{"ld_a_hi ", 1'b0, 32'h0000_1040, 64'h0, 8'h00, 1'b1,
                     64'h1122_3344_CCCC_DDDD};
        rows[9]  = '{"st_x_81 ", 1'b1, 32'h0000_0200, 64'hDEAD_BEEF_0BAD_F00D, 8'h81,
                     1'b0, 64'h0};
        rows[10] = '{"ld_x_81 ", 1'b0, 32'h0000_0200, 64'h0, 8'h00, 1'b1,
                     64'hDE00_0200_0000_020D};
        rows[11] = '{"ld_b_cln", 1'b0, 32'h0000_2040, 64'h0, 8'h00, 1'b1,
                     64'h0000_2040_0000_2040};
        rows[12] = '{"ld_open ", 1'b0, 32'h0000_4040, 64'h0, 8'h00, 1'b0, 64'h0};
        rows[13] = '{"ld_a_fin", 1'b0, 32'h0000_1040, 64'h0, 8'h00, 1'b1,
                     64'h1122_3344_CCCC_DDDD};

        clk           = 1'b0;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        rsp_ready     = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        row_name      = '0;
        row_fixed     = 1'b0;
        row_exp       = '0;
        cycle_count   = 0;
        count_errors  = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        for (int r = 0; r < ROWS; r++) begin
            req_valid  <= 1'b1;
            req.addr   <= rows[r].addr;
            req.we     <= rows[r].we;
            req.wdata  <= rows[r].data;
            req.mask   <= rows[r].mask;
            row_name   <= rows[r].name;
            row_fixed  <= rows[r].fixed;
            row_exp    <= rows[r].exp_data;
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        req_valid <= 1'b0;

        while (rsp_count < ROWS) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        if (rsp_count != ROWS) begin
            $display("response count %0d does not match %0d requests", rsp_count, ROWS);
            count_errors = count_errors + 1;
        end

        $display("errors: %0d checker, %0d assertion, %0d count",
                 check_errors, u_dut.u_assertions.fail_count, count_errors);
        if (check_errors == 0 && u_dut.u_assertions.fail_count == 0 && count_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
